// File: common/board_pkg.sv
//*********************************************************************
// shared types for the scan converter board glue logic
// widths, video and audio stream structs, control word fields
// referenced everywhere with scoped names, never imported
//*********************************************************************

package board_pkg;

    // synchronizer depth for async board inputs
    localparam int unsigned SYNC_STAGES = 2;

    // default resync LED stretch counter width, about 0.6 s at 27 MHz
    localparam int unsigned STRETCH_W_DEFAULT = 24;

    // led vector bit positions
    localparam int unsigned LED_RESYNC_BIT = 0;
    localparam int unsigned LED_NO_IR_BIT  = 1;

    // unused top bits of the status word
    localparam int unsigned STATUS_PAD_W = 6;

    // one colour channel
    typedef logic [7:0]  pixel_t;
    // horizontal or vertical position from a frontend
    typedef logic [10:0] pos_t;

    // front panel buttons, active low
    typedef logic [1:0]  btn_t;
    // decoded remote code and its running counter
    typedef logic [15:0] ir_code_t;
    typedef logic [7:0]  ir_cnt_t;

    // word read back by the system controller
    typedef logic [31:0] status_word_t;

    // board LEDs
    typedef logic [1:0]  led_t;

    // video stream as delivered by either frontend
    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
        logic   hsync;
        logic   vsync;
        logic   de;
        logic   fid;
        logic   interlace;
        logic   frame_change;
        pos_t   xpos;
        pos_t   ypos;
    } video_t;

    // I2S lines
    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } audio_t;

    // system control word, fields listed from bit 15 down to bit 0
    typedef struct packed {
        logic [6:0] reserved;
        logic       audmux_sel;
        logic       isl_vs_type;
        logic       isl_vs_pol;
        logic       capture_sel;
        // memory controller resets, not used on this board revision
        logic       emif_sw;
        logic       emif_hw;
        logic       hdmirx_reset_n;
        logic       isl_reset_n;
        logic       extra;
    } ctrl_word_t;

endpackage

// File: capture/capture_select.sv
//*********************************************************************
// capture source selection for the scaler input
// registers the chosen video stream on clk27 and routes the audio
// of the same source straight through to the HDMI transmitter
//*********************************************************************

module capture_select (
    input  logic              clk27,
    input  logic              po_reset_n,

    // 0 selects the analog digitizer, 1 the HDMI receiver
    input  logic              capture_sel_i,

    input  board_pkg::video_t isl_video_i,
    input  board_pkg::video_t hdmirx_video_i,

    input  board_pkg::audio_t pcm_audio_i,
    input  board_pkg::audio_t hdmirx_audio_i,

    output board_pkg::video_t video_o,
    output board_pkg::audio_t audio_o
);

    // selected stream ahead of the capture register
    board_pkg::video_t video_sel;
    // capture register
    board_pkg::video_t video_q;

    // video mux
    // whole struct switches at once so sync and position stay aligned
    // with the pixel data of the same source
    always_comb begin
        if (capture_sel_i) begin
            video_sel = hdmirx_video_i;
        end else begin
            video_sel = isl_video_i;
        end
    end

    // capture register, one cycle of latency
    // cleared in reset so the scaler sees blank, sync-less input
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            video_q <= '0;
        end else begin
            video_q <= video_sel;
        end
    end

    assign video_o = video_q;

    // audio routing
    // no register here, bck and ws already carry their own timing
    // and the transmitter samples them on bck
    always_comb begin
        if (capture_sel_i) begin
            audio_o = hdmirx_audio_i;
        end else begin
            // analog path takes the external PCM codec
            audio_o = pcm_audio_i;
        end
    end

endmodule

// File: panel/panel_inputs.sv
//*********************************************************************
// front panel and IR receiver inputs
// brings buttons and the IR line into the clk27 domain and packs
// the status word read by the system controller
//*********************************************************************

module panel_inputs (
    input  logic                    clk27,
    input  logic                    po_reset_n,

    // asynchronous board pins
    input  board_pkg::btn_t         btn_i,
    input  logic                    ir_rx_i,

    // from the IR decoder
    input  board_pkg::ir_code_t     ir_code_i,
    input  board_pkg::ir_cnt_t      ir_code_cnt_i,

    // synchronized IR line for the decoder
    output logic                    ir_rx_o,
    output board_pkg::status_word_t status_o
);

    // synchronizer chains, index 0 samples the pin
    board_pkg::btn_t [board_pkg::SYNC_STAGES-1:0] btn_sync_q;
    logic [board_pkg::SYNC_STAGES-1:0]            ir_sync_q;

    // last stage of the button chain
    board_pkg::btn_t btn_sync;

    // buttons and IR idle high, so reset to ones
    // avoids a fake press or IR edge right after reset
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync_q <= '1;
            ir_sync_q  <= '1;
        end else begin
            btn_sync_q <= {btn_sync_q[board_pkg::SYNC_STAGES-2:0], btn_i};
            ir_sync_q  <= {ir_sync_q[board_pkg::SYNC_STAGES-2:0], ir_rx_i};
        end
    end

    assign btn_sync = btn_sync_q[board_pkg::SYNC_STAGES-1];
    assign ir_rx_o  = ir_sync_q[board_pkg::SYNC_STAGES-1];

    // status word
    // bits 0..15 ir code, 16..23 code count, 24..25 buttons, rest zero
    assign status_o = {
        {board_pkg::STATUS_PAD_W{1'b0}},
        btn_sync,
        ir_code_cnt_i,
        ir_code_i
    };

endmodule

// File: panel/resync_indicator.sv
//*********************************************************************
// resync indicator LED
// catches the scaler resync strobe, stretches each rising edge into
// a visible pulse and flags when no remote code has been received
//*********************************************************************

module resync_indicator #(
    // pulse length is 2**STRETCH_W - 1 cycles, must be 2 or more
    parameter int unsigned STRETCH_W = board_pkg::STRETCH_W_DEFAULT
) (
    input  logic                clk27,
    input  logic                po_reset_n,

    // strobe from the scaler, not related to clk27
    input  logic                resync_strobe_i,
    input  board_pkg::ir_code_t ir_code_i,

    output board_pkg::led_t     led_o
);

    // strobe synchronizer and previous synchronized value
    logic [board_pkg::SYNC_STAGES-1:0] strobe_sync_q;
    logic                              strobe_prev_q;
    logic                              strobe_rise;

    // stretch counter, LED on while nonzero
    logic [STRETCH_W-1:0] stretch_ctr_q;

    assign strobe_rise = strobe_sync_q[board_pkg::SYNC_STAGES-1] & ~strobe_prev_q;

    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync_q <= '0;
            strobe_prev_q <= 1'b0;
            stretch_ctr_q <= '0;
        end else begin
            strobe_sync_q <= {strobe_sync_q[board_pkg::SYNC_STAGES-2:0], resync_strobe_i};
            strobe_prev_q <= strobe_sync_q[board_pkg::SYNC_STAGES-1];
            // a new edge restarts the full pulse, even mid-pulse
            if (strobe_rise) begin
                stretch_ctr_q <= '1;
            end else if (stretch_ctr_q != '0) begin
                stretch_ctr_q <= stretch_ctr_q - 1'b1;
            end
        end
    end

    // led drive
    assign led_o[board_pkg::LED_RESYNC_BIT] = (stretch_ctr_q != '0);
    // code zero means the decoder has not latched anything yet
    assign led_o[board_pkg::LED_NO_IR_BIT]  = (ir_code_i == '0);

endmodule

// File: logic/ossc_board_top.sv
//*********************************************************************
// board glue top level of the scan converter
// decodes the system control word and connects the capture mux,
// the panel inputs and the resync indicator, all on clk27
//*********************************************************************

module ossc_board_top #(
    // resync LED stretch width, shortened in simulation
    parameter int unsigned STRETCH_W = board_pkg::STRETCH_W_DEFAULT
) (
    input  logic                    clk27,
    input  logic                    po_reset_n,

    // control word from the system controller
    input  board_pkg::ctrl_word_t   sys_ctrl_i,

    // video and audio sources
    input  board_pkg::video_t       isl_video_i,
    input  board_pkg::video_t       hdmirx_video_i,
    input  board_pkg::audio_t       pcm_audio_i,
    input  board_pkg::audio_t       hdmirx_audio_i,

    // panel and IR
    input  board_pkg::btn_t         btn_i,
    input  logic                    ir_rx_i,
    input  board_pkg::ir_code_t     ir_code_i,
    input  board_pkg::ir_cnt_t      ir_code_cnt_i,

    // strobe from the scaler
    input  logic                    resync_strobe_i,

    // decoded control outputs
    output logic                    isl_reset_n_o,
    output logic                    hdmirx_reset_n_o,
    output logic                    audmux_o,
    output logic                    isl_vs_pol_o,
    output logic                    isl_vs_type_o,

    output board_pkg::status_word_t status_o,
    output logic                    ir_rx_o,
    output board_pkg::led_t         led_o,
    output board_pkg::video_t       video_o,
    output board_pkg::audio_t       audio_o
);

    // capture source select, also steers audio
    logic capture_sel;

    // control word split
    // the remaining fields have no consumer on this board
    assign capture_sel      = sys_ctrl_i.capture_sel;
    assign isl_reset_n_o    = sys_ctrl_i.isl_reset_n;
    assign hdmirx_reset_n_o = sys_ctrl_i.hdmirx_reset_n;
    assign audmux_o         = sys_ctrl_i.audmux_sel;
    // vsync handling options for the digitizer frontend
    assign isl_vs_pol_o     = sys_ctrl_i.isl_vs_pol;
    assign isl_vs_type_o    = sys_ctrl_i.isl_vs_type;

    capture_select u_capture_select (
        .clk27          (clk27),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (capture_sel),
        .isl_video_i    (isl_video_i),
        .hdmirx_video_i (hdmirx_video_i),
        .pcm_audio_i    (pcm_audio_i),
        .hdmirx_audio_i (hdmirx_audio_i),
        .video_o        (video_o),
        .audio_o        (audio_o)
    );

    panel_inputs u_panel_inputs (
        .clk27          (clk27),
        .po_reset_n     (po_reset_n),
        .btn_i          (btn_i),
        .ir_rx_i        (ir_rx_i),
        .ir_code_i      (ir_code_i),
        .ir_code_cnt_i  (ir_code_cnt_i),
        .ir_rx_o        (ir_rx_o),
        .status_o       (status_o)
    );

    resync_indicator #(
        .STRETCH_W (STRETCH_W)
    ) u_resync_indicator (
        .clk27           (clk27),
        .po_reset_n      (po_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .ir_code_i       (ir_code_i),
        .led_o           (led_o)
    );

endmodule

// File: test/tb_clock.sv
//*********************************************************************
// testbench clock and reset source
// 27 MHz board clock modelled with a period of 100 time units
// po_reset_n held low for two clock cycles, then released
//*********************************************************************

module tb_clock (
    output logic clk27,
    output logic po_reset_n
);

    initial begin
        clk27 = 1'b0;
        forever begin
            #50 clk27 = ~clk27;
        end
    end

    // release away from the rising edge
    initial begin
        po_reset_n = 1'b0;
        repeat (2) @(posedge clk27);
        @(negedge clk27);
        po_reset_n = 1'b1;
    end

endmodule

// File: test/board_sva.sv
//*********************************************************************
// concurrent checks bound into the capture mux and the resync LED
// one module, each bind enables the checks that apply to its target
//*********************************************************************

module board_sva #(
    parameter int unsigned CHECK_VIDEO = 0,
    parameter int unsigned CHECK_LED   = 0
) (
    input logic              clk27,
    input logic              po_reset_n,
    input board_pkg::video_t video_i,
    input board_pkg::led_t   led_i
);

    if (CHECK_VIDEO != 0) begin : g_video
        // capture register must come out of reset cleared
        video_zero_after_reset: assert property (
            @(posedge clk27) $rose(po_reset_n) |-> (video_i == '0)
        ) else $error("video_o not zero in the first cycle after reset");
    end

    if (CHECK_LED != 0) begin : g_led
        // a fall needs the LED high for the full 15 cycle stretch
        // a retrigger only makes the high time longer
        led_min_pulse: assert property (
            @(posedge clk27) disable iff (!po_reset_n)
            $fell(led_i[0]) |-> $past(led_i[0], 15)
        ) else $error("resync LED pulse shorter than 15 cycles");
    end

endmodule

bind capture_select board_sva #(
    .CHECK_VIDEO (1),
    .CHECK_LED   (0)
) u_board_sva (
    .clk27      (clk27),
    .po_reset_n (po_reset_n),
    .video_i    (video_o),
    .led_i      (2'b00)
);

bind resync_indicator board_sva #(
    .CHECK_VIDEO (0),
    .CHECK_LED   (1)
) u_board_sva (
    .clk27      (clk27),
    .po_reset_n (po_reset_n),
    .video_i    ('0),
    .led_i      (led_o)
);

// File: test/tb_top.sv
//*********************************************************************
// testbench for the board glue top level
// one line of test/board_cases.txt per clock cycle, inputs applied
// after the rising edge, outputs compared just before the next one
//*********************************************************************

module tb_top;

    localparam int unsigned CLK_PERIOD      = 100;
    localparam int unsigned DRIVE_DELAY     = 10;
    localparam int unsigned SAMPLE_DELAY    = 89;
    localparam int unsigned CYCLES_PER_CASE = 40;

    // one clock cycle of stimulus and the outputs expected in it
    typedef struct packed {
        board_pkg::ctrl_word_t   ctrl;
        board_pkg::video_t       isl_video;
        board_pkg::video_t       hdmirx_video;
        board_pkg::audio_t       pcm_audio;
        board_pkg::audio_t       hdmirx_audio;
        board_pkg::btn_t         btn;
        logic                    ir_rx;
        board_pkg::ir_code_t     ir_code;
        board_pkg::ir_cnt_t      ir_code_cnt;
        logic                    strobe;
        board_pkg::video_t       exp_video;
        board_pkg::audio_t       exp_audio;
        board_pkg::status_word_t exp_status;
        logic                    exp_ir_rx;
        board_pkg::led_t         exp_led;
    } test_case_t;

    logic                    clk27;
    logic                    po_reset_n;
    board_pkg::ctrl_word_t   sys_ctrl;
    board_pkg::video_t       isl_video;
    board_pkg::video_t       hdmirx_video;
    board_pkg::audio_t       pcm_audio;
    board_pkg::audio_t       hdmirx_audio;
    board_pkg::btn_t         btn;
    logic                    ir_rx;
    board_pkg::ir_code_t     ir_code;
    board_pkg::ir_cnt_t      ir_code_cnt;
    logic                    resync_strobe;
    logic                    isl_reset_n;
    logic                    hdmirx_reset_n;
    logic                    audmux;
    logic                    isl_vs_pol;
    logic                    isl_vs_type;
    board_pkg::status_word_t status;
    logic                    ir_rx_sync;
    board_pkg::led_t         led;
    board_pkg::video_t       video;
    board_pkg::audio_t       audio;

    test_case_t cases[$];
    bit         cases_loaded = 1'b0;

    tb_clock u_clock (
        .clk27      (clk27),
        .po_reset_n (po_reset_n)
    );

    ossc_board_top #(
        .STRETCH_W (4)
    ) UUT (
        .clk27            (clk27),
        .po_reset_n       (po_reset_n),
        .sys_ctrl_i       (sys_ctrl),
        .isl_video_i      (isl_video),
        .hdmirx_video_i   (hdmirx_video),
        .pcm_audio_i      (pcm_audio),
        .hdmirx_audio_i   (hdmirx_audio),
        .btn_i            (btn),
        .ir_rx_i          (ir_rx),
        .ir_code_i        (ir_code),
        .ir_code_cnt_i    (ir_code_cnt),
        .resync_strobe_i  (resync_strobe),
        .isl_reset_n_o    (isl_reset_n),
        .hdmirx_reset_n_o (hdmirx_reset_n),
        .audmux_o         (audmux),
        .isl_vs_pol_o     (isl_vs_pol),
        .isl_vs_type_o    (isl_vs_type),
        .status_o         (status),
        .ir_rx_o          (ir_rx_sync),
        .led_o            (led),
        .video_o          (video),
        .audio_o          (audio)
    );

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_video(string name, board_pkg::video_t act, board_pkg::video_t exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h expected %h", name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_audio(string name, board_pkg::audio_t act, board_pkg::audio_t exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h expected %h", name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_status(string name, board_pkg::status_word_t act,
                                board_pkg::status_word_t exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h expected %h", name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_led(string name, board_pkg::led_t act, board_pkg::led_t exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h expected %h", name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h expected %h", name, act, exp);
            stop_on_error();
        end
    endtask

    // reads every case line, lines starting with # are notes
    task automatic load_cases();
        int                                    fd;
        int                                    n;
        string                                 line;
        test_case_t                            tc;
        logic [15:0]                           f_ctrl;
        logic [$bits(board_pkg::video_t)-1:0]  f_isl;
        logic [$bits(board_pkg::video_t)-1:0]  f_hdmi;
        logic [$bits(board_pkg::video_t)-1:0]  f_evid;
        logic [2:0]                            f_pcm;
        logic [2:0]                            f_haud;
        logic [2:0]                            f_eaud;
        logic [1:0]                            f_btn;
        logic [1:0]                            f_eled;
        logic                                  f_irrx;
        logic                                  f_stb;
        logic                                  f_eirrx;
        logic [15:0]                           f_code;
        logic [7:0]                            f_cnt;
        logic [31:0]                           f_estat;
        fd = $fopen("test/board_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file test/board_cases.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_ctrl, f_isl, f_hdmi, f_pcm, f_haud, f_btn, f_irrx,
                        f_code, f_cnt, f_stb, f_evid, f_eaud, f_estat, f_eirrx, f_eled);
            if (n != 15) begin
                $display("malformed case line: %s", line);
                stop_on_error();
            end
            tc.ctrl         = f_ctrl;
            tc.isl_video    = f_isl;
            tc.hdmirx_video = f_hdmi;
            tc.pcm_audio    = f_pcm;
            tc.hdmirx_audio = f_haud;
            tc.btn          = f_btn;
            tc.ir_rx        = f_irrx;
            tc.ir_code      = f_code;
            tc.ir_code_cnt  = f_cnt;
            tc.strobe       = f_stb;
            tc.exp_video    = f_evid;
            tc.exp_audio    = f_eaud;
            tc.exp_status   = f_estat;
            tc.exp_ir_rx    = f_eirrx;
            tc.exp_led      = f_eled;
            cases.push_back(tc);
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            $display("the case file holds no cases");
            stop_on_error();
        end
    endtask

    task automatic apply_case(test_case_t tc);
        sys_ctrl      = tc.ctrl;
        isl_video     = tc.isl_video;
        hdmirx_video  = tc.hdmirx_video;
        pcm_audio     = tc.pcm_audio;
        hdmirx_audio  = tc.hdmirx_audio;
        btn           = tc.btn;
        ir_rx         = tc.ir_rx;
        ir_code       = tc.ir_code;
        ir_code_cnt   = tc.ir_code_cnt;
        resync_strobe = tc.strobe;
    endtask

    task automatic compare_outputs(test_case_t tc);
        logic [15:0] ctrl_bits;
        ctrl_bits = tc.ctrl;
        check_video("video_o", video, tc.exp_video);
        check_audio("audio_o", audio, tc.exp_audio);
        check_status("status_o", status, tc.exp_status);
        check_bit("ir_rx_o", ir_rx_sync, tc.exp_ir_rx);
        check_led("led_o", led, tc.exp_led);
        // control word bits from 0 up are extra, isl reset, hdmirx reset,
        // emif hw and sw, capture select, vs polarity, vs type and audio mux
        check_bit("isl_reset_n_o", isl_reset_n, ctrl_bits[1]);
        check_bit("hdmirx_reset_n_o", hdmirx_reset_n, ctrl_bits[2]);
        check_bit("audmux_o", audmux, ctrl_bits[8]);
        check_bit("isl_vs_pol_o", isl_vs_pol, ctrl_bits[6]);
        check_bit("isl_vs_type_o", isl_vs_type, ctrl_bits[7]);
    endtask

    // idle board: buttons released, IR line high, no strobe
    initial begin
        sys_ctrl      = '0;
        isl_video     = '0;
        hdmirx_video  = '0;
        pcm_audio     = '0;
        hdmirx_audio  = '0;
        btn           = 2'b11;
        ir_rx         = 1'b1;
        ir_code       = '0;
        ir_code_cnt   = '0;
        resync_strobe = 1'b0;
    end

    initial begin
        load_cases();
        cases_loaded = 1'b1;
        wait (po_reset_n === 1'b1);
        @(posedge clk27);
        foreach (cases[i]) begin
            #(DRIVE_DELAY);
            apply_case(cases[i]);
            #(SAMPLE_DELAY);
            compare_outputs(cases[i]);
            @(posedge clk27);
        end
        $display("Verification passed");
        $finish;
    end

    // watchdog scaled to the number of cases
    initial begin
        wait (cases_loaded);
        #(longint'(cases.size()) * CYCLES_PER_CASE * CLK_PERIOD);
        $display("timeout: the cases did not finish within the watchdog limit");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

// File: test/board_cases.txt
# ctrl isl_video hdmirx_video pcm hdmirx_aud btn ir_rx ir_code ir_cnt strobe (all hex)
# exp_video exp_audio exp_status exp_ir_rx exp_led, one line per clock cycle
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 00000000000 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 5 03071234 1 0
0026 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 2 03071234 1 0
0026 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 5135792468A 2 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 5135792468A 5 03071234 1 0
0006 0FEDCBA9876 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 5 03071234 1 0
0006 0FEDCBA9876 5135792468A 5 2 3 1 1234 07 0 0FEDCBA9876 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 0FEDCBA9876 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 5 03071234 1 0
01C7 2ABCDEF0123 5135792468A 7 2 3 1 1234 07 0 2ABCDEF0123 7 03071234 1 0
00D9 2ABCDEF0123 5135792468A 0 2 3 1 1234 07 0 2ABCDEF0123 0 03071234 1 0
0158 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 2 1 1234 07 0 2ABCDEF0123 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 2 0 1234 07 0 2ABCDEF0123 5 03071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 0 0 1234 07 0 2ABCDEF0123 5 02071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 0 1 1234 07 0 2ABCDEF0123 5 02071234 0 0
0006 2ABCDEF0123 5135792468A 5 2 1 1 1234 07 0 2ABCDEF0123 5 00071234 0 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 1234 07 0 2ABCDEF0123 5 00071234 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 0000 08 0 2ABCDEF0123 5 01080000 1 2
0006 2ABCDEF0123 5135792468A 5 2 3 1 0000 08 0 2ABCDEF0123 5 03080000 1 2
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 1 2ABCDEF0123 5 03FFABCD 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 1 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 0000 FF 0 2ABCDEF0123 5 03FF0000 1 3
0006 2ABCDEF0123 5135792468A 5 2 3 1 0000 FF 0 2ABCDEF0123 5 03FF0000 1 3
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 1
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 0
0006 2ABCDEF0123 5135792468A 5 2 3 1 ABCD FF 0 2ABCDEF0123 5 03FFABCD 1 0

// File: sources.f
common/board_pkg.sv
capture/capture_select.sv
panel/panel_inputs.sv
panel/resync_indicator.sv
logic/ossc_board_top.sv
test/tb_clock.sv
test/board_sva.sv
test/tb_top.sv

// File: Makefile
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST) test/board_cases.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "simulation reported failure" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
